// ==== Bender.yml ====
package:
  name: vram_subsystem

sources:
  - source/vram_pkg.sv
  - source/vram_sram.sv
  - source/vram_interface.sv
  - source/bg_tile_fetcher.sv
  - source/oam_dma.sv
  - source/vram_subsystem.sv
  - target: test
    files:
      - dv/vram_subsystem_tb.sv

// ==== dv/vram_subsystem_tb.sv ====
`timescale 1ns/1ps

module vram_subsystem_tb;

	localparam int FILL_CYCLES = 3 * 8192;
	localparam int TEST_CYCLES = 4000; // Reads, lockout, fetches, two DMA runs.
	localparam int WATCHDOG_NS = (16 + FILL_CYCLES + TEST_CYCLES) * 4 + 1000;

	logic        clk = 1'b0;
	logic        arst_n;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata;
	logic        cpu_rd;
	logic        cpu_wr;
	logic        ppu_mode3;
	logic        fetch_start;
	logic [4:0]  fetch_col;
	logic [7:0]  line_y;
	logic        lcdc_map_sel;
	logic        lcdc_tile_sel;
	logic [7:0]  cpu_rdata;
	logic        cpu_rvalid;
	logic [7:0]  tile_lo;
	logic [7:0]  tile_hi;
	logic        tile_valid;
	logic        fetch_busy;
	logic        dma_busy;
	logic        oam_we;
	logic [7:0]  oam_addr;
	logic [7:0]  oam_wdata;

	logic [7:0]  shadow [8192];
	logic [15:0] lfsr = 16'd18;
	logic [15:0] saved_addr [16];
	logic [4:0]  pick_col;
	logic [7:0]  pick_line;
	int          errors;
	int          errs_start;
	int          tests_run;
	int          tests_failed;
	int          dma_k;
	int          dma_base;
	int          pulses;
	string       test_name;

	vram_subsystem vram_subsystem_inst (.*);

	always #2 clk = ~clk;

	initial begin
		#(WATCHDOG_NS);
		$display("Run stalled: the watchdog expired before all tests finished");
		$display("Verification failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [12:0] map_addr_of(input logic [4:0] col, input logic [7:0] line,
		input logic map);
		int a;
		a = (map ? 'h1C00 : 'h1800) + 32 * (line / 8) + col;
		return a[12:0];
	endfunction

	// Returns {high plane, low plane} from the shadow copy.
	function automatic logic [15:0] expect_tile(input logic [4:0] col, input logic [7:0] line,
		input logic map, input logic tsel);
		logic [7:0] idx;
		int         s;
		int         a;
		idx = shadow[map_addr_of(col, line, map)];
		if (tsel) begin
			a = idx * 16;
		end else begin
			s = $signed(idx);
			a = 'h1000 + s * 16;
		end
		a = a + 2 * (line % 8);
		return {shadow[(a + 1) & 'h1FFF], shadow[a & 'h1FFF]};
	endfunction

	task automatic flag_mismatch(input string what, input int exp, input int act);
		errors++;
		$display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
	endtask

	task automatic flag_event(input string what);
		errors++;
		$display("%s: %s", test_name, what);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errs_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors > errs_start) begin
			tests_failed++;
		end
		$display("test %s: %0d errors", test_name, errors - errs_start);
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		logic lock;
		@(posedge clk);
		cpu_addr  <= addr;
		cpu_wdata <= data;
		cpu_wr    <= 1'b1;
		@(negedge clk);
		lock = ppu_mode3 || dma_busy;
		@(posedge clk);
		cpu_wr <= 1'b0;
		if (addr[15:13] == 3'b100 && !lock) begin
			shadow[addr[12:0]] = data;
		end
	endtask

	task automatic cpu_read(input logic [15:0] addr, input logic [7:0] exp);
		@(posedge clk);
		cpu_addr <= addr;
		cpu_rd   <= 1'b1;
		@(posedge clk);
		cpu_rd <= 1'b0;
		@(negedge clk);
		assert (cpu_rvalid) else flag_event("cpu_rvalid missing after a window read");
		assert (cpu_rdata == exp) else flag_mismatch("cpu_rdata", exp, cpu_rdata);
	endtask

	task automatic run_fetch(input logic [4:0] col, input logic [7:0] line, input logic map,
		input logic tsel);
		logic [15:0] exp;
		exp = expect_tile(col, line, map, tsel);
		@(posedge clk);
		fetch_start   <= 1'b1;
		fetch_col     <= col;
		line_y        <= line;
		lcdc_map_sel  <= map;
		lcdc_tile_sel <= tsel;
		@(posedge clk);
		fetch_start <= 1'b0;
		for (int i = 0; i < 8 && !tile_valid; i++) begin
			@(negedge clk);
		end
		if (!tile_valid) begin
			flag_event("tile_valid never rose after fetch_start");
		end else begin
			assert (tile_lo == exp[7:0]) else flag_mismatch("tile_lo", exp[7:0], tile_lo);
			assert (tile_hi == exp[15:8]) else flag_mismatch("tile_hi", exp[15:8], tile_hi);
		end
	endtask

	task automatic wait_dma_done();
		for (int i = 0; i < 600 && dma_busy; i++) begin
			@(negedge clk);
		end
		assert (!dma_busy) else flag_event("dma_busy stuck high");
		assert (dma_k == 160) else flag_mismatch("oam_we count", 160, dma_k);
	endtask

	////////////////////////////////////////////////////////////
	// Assertions and OAM monitor
	////////////////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (!arst_n)
		cpu_rvalid == $past(cpu_rd && cpu_addr[15:13] == 3'b100))
		else flag_event("cpu_rvalid did not follow the window read by one cycle");
	assert property (@(posedge clk) disable iff (!arst_n)
		(fetch_start && !fetch_busy) |-> ##5 tile_valid) // Valid after the fourth edge.
		else flag_event("tile_valid missed its latency after fetch_start");
	assert property (@(posedge clk) disable iff (!arst_n)
		(fetch_start && !fetch_busy) |=> fetch_busy ##1 fetch_busy ##1 fetch_busy
		##1 fetch_busy ##1 !fetch_busy)
		else flag_event("fetch_busy did not span exactly the four fetch cycles");
	assert property (@(posedge clk) disable iff (!arst_n) tile_valid |=> !tile_valid)
		else flag_event("tile_valid held longer than one cycle");
	assert property (@(posedge clk) disable iff (!arst_n) oam_we |-> dma_busy)
		else flag_event("oam_we seen while the DMA was idle");
	assert property (@(posedge clk) disable iff (!arst_n)
		(oam_we && oam_addr == 8'd159) |=> !dma_busy)
		else flag_event("dma_busy stayed high after the last oam_we");

	always @(negedge clk) begin
		if (arst_n && oam_we) begin
			assert (oam_addr == dma_k) else flag_mismatch("oam_addr", dma_k, oam_addr);
			assert (oam_wdata == shadow[(dma_base + dma_k) & 'h1FFF])
				else flag_mismatch("oam_wdata", shadow[(dma_base + dma_k) & 'h1FFF], oam_wdata);
			dma_k++;
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		arst_n = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		ppu_mode3 = 1'b0;
		fetch_start = 1'b0;
		fetch_col = '0;
		line_y = '0;
		lcdc_map_sel = 1'b0;
		lcdc_tile_sel = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		dma_k = 0;
		dma_base = 0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);

		begin_test("reset_and_rw");
		assert (!cpu_rvalid && !tile_valid && !fetch_busy && !dma_busy && !oam_we)
			else flag_event("a control output was high after reset");
		for (int a = 0; a < 8192; a++) begin
			cpu_write(16'h8000 + a, rand_bits(8));
		end
		for (int i = 0; i < 48; i++) begin
			saved_addr[0] = 16'h8000 | rand_bits(13);
			cpu_write(saved_addr[0], rand_bits(8));
			cpu_read(saved_addr[0], shadow[saved_addr[0][12:0]]);
		end
		end_test();

		begin_test("mode3_lockout");
		@(posedge clk);
		ppu_mode3 <= 1'b1;
		for (int i = 0; i < 16; i++) begin
			saved_addr[i] = 16'h8000 | rand_bits(13);
			cpu_write(saved_addr[i], ~shadow[saved_addr[i][12:0]]);
			cpu_read(saved_addr[i], 8'hFF);
		end
		@(posedge clk);
		cpu_addr <= 16'hC000 | rand_bits(13); // Outside the window.
		cpu_rd   <= 1'b1;
		@(posedge clk);
		cpu_rd <= 1'b0;
		@(negedge clk);
		assert (!cpu_rvalid) else flag_event("cpu_rvalid raised for a read outside the window");
		@(posedge clk);
		ppu_mode3 <= 1'b0;
		for (int i = 0; i < 16; i++) begin
			cpu_read(saved_addr[i], shadow[saved_addr[i][12:0]]);
		end
		end_test();

		begin_test("fetch_unsigned");
		@(posedge clk);
		ppu_mode3 <= 1'b1;
		for (int i = 0; i < 16; i++) begin
			run_fetch(rand_bits(5), rand_bits(8), i[0], 1'b1);
		end
		end_test();

		begin_test("fetch_signed");
		for (int j = 0; j < 8; j++) begin
			pick_col = rand_bits(5);
			pick_line = rand_bits(8);
			@(posedge clk);
			ppu_mode3 <= 1'b0;
			cpu_write(16'h8000 + map_addr_of(pick_col, pick_line, j[0]), {j[1], 7'(rand_bits(7))});
			@(posedge clk);
			ppu_mode3 <= 1'b1;
			run_fetch(pick_col, pick_line, j[0], 1'b0);
		end
		saved_addr[0] = expect_tile(5'd3, 8'd21, 1'b0, 1'b0);
		@(posedge clk);
		fetch_start <= 1'b1;
		fetch_col   <= 5'd3;
		line_y      <= 8'd21;
		lcdc_map_sel <= 1'b0;
		@(posedge clk);
		fetch_start <= 1'b0;
		@(posedge clk);
		fetch_start <= 1'b1; // Arrives while busy.
		fetch_col   <= 5'd4;
		@(posedge clk);
		fetch_start <= 1'b0;
		pulses = 0;
		repeat (10) begin
			@(negedge clk);
			if (tile_valid) begin
				pulses++;
				assert (tile_lo == saved_addr[0][7:0])
					else flag_mismatch("tile_lo", saved_addr[0][7:0], tile_lo);
			end
		end
		assert (pulses == 1) else flag_mismatch("tile_valid pulses", 1, pulses);
		end_test();

		begin_test("dma_copy");
		@(posedge clk);
		ppu_mode3 <= 1'b0;
		saved_addr[0] = 16'h0080 + rand_bits(5);
		dma_base = (saved_addr[0] - 'h80) * 256;
		dma_k = 0;
		cpu_write(16'hFF46, saved_addr[0][7:0]);
		cpu_read(16'h8000 | rand_bits(13), 8'hFF);
		wait_dma_done();
		cpu_write(16'hFF46, 8'hA0 + rand_bits(5));
		repeat (4) @(negedge clk);
		assert (!dma_busy) else flag_event("dma_busy rose for a page above VRAM");
		cpu_write(16'hFF46, 8'h7F);
		repeat (4) @(negedge clk);
		assert (!dma_busy) else flag_event("dma_busy rose for a page below VRAM");
		end_test();

		begin_test("dma_with_fetch");
		saved_addr[0] = 16'h0080 + rand_bits(5);
		dma_base = (saved_addr[0] - 'h80) * 256;
		dma_k = 0;
		cpu_write(16'hFF46, saved_addr[0][7:0]);
		@(posedge clk);
		ppu_mode3 <= 1'b1;
		for (int i = 0; i < 40 && dma_busy; i++) begin
			run_fetch(rand_bits(5), rand_bits(8), rand_bits(1), rand_bits(1));
		end
		wait_dma_done();
		end_test();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== source/bg_tile_fetcher.sv ====
`timescale 1ns/1ps

module bg_tile_fetcher (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 fetch_start,
	input  vram_pkg::tile_col_t  fetch_col,
	input  vram_pkg::line_t      line_y,
	input  logic                 lcdc_map_sel,
	input  logic                 lcdc_tile_sel,
	output logic                 fetch_req,
	output vram_pkg::vram_addr_t fetch_addr,
	input  vram_pkg::byte_t      fetch_rdata,
	output vram_pkg::byte_t      tile_lo,
	output vram_pkg::byte_t      tile_hi,
	output logic                 tile_valid,
	output logic                 fetch_busy
);

	vram_pkg::fetch_state_t state_q;
	logic                   hi_pend_q;

	vram_pkg::tile_col_t col_q;
	vram_pkg::line_t     line_q;
	logic                map_sel_q;
	logic                tile_sel_q;
	vram_pkg::byte_t     idx_q;
	vram_pkg::byte_t     lo_q;

	vram_pkg::byte_t      idx;
	vram_pkg::vram_addr_t map_base;
	vram_pkg::vram_addr_t map_addr;
	vram_pkg::vram_addr_t row_off;
	vram_pkg::vram_addr_t tile_addr;

	assign fetch_busy = (state_q != vram_pkg::FETCH_IDLE) || hi_pend_q;
	assign fetch_req  = (state_q != vram_pkg::FETCH_IDLE);

	////////////////////////////////////////////////////////////
	// Address generation
	////////////////////////////////////////////////////////////

	assign map_base = map_sel_q ? vram_pkg::BG_MAP1_BASE : vram_pkg::BG_MAP0_BASE;
	assign map_addr = map_base + vram_pkg::vram_addr_t'({line_q[7:3], col_q});
	assign row_off  = vram_pkg::vram_addr_t'({line_q[2:0], 1'b0});

	// Index comes straight off the bus in the low-byte cycle.
	assign idx = (state_q == vram_pkg::FETCH_LOW) ? fetch_rdata : idx_q;

	always_comb begin
		if (tile_sel_q) begin
			tile_addr = vram_pkg::vram_addr_t'({idx, 4'h0}) + row_off;
		end else begin
			tile_addr = vram_pkg::TILE_SIGNED_BASE + {idx[7], idx, 4'h0} + row_off;
		end
	end

	always_comb begin
		case (state_q)
			vram_pkg::FETCH_MAP:  fetch_addr = map_addr;
			vram_pkg::FETCH_HIGH: fetch_addr = tile_addr + 13'd1;
			default:              fetch_addr = tile_addr;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q    <= vram_pkg::FETCH_IDLE;
			hi_pend_q  <= 1'b0;
			tile_valid <= 1'b0;
		end else begin
			hi_pend_q  <= (state_q == vram_pkg::FETCH_HIGH);
			tile_valid <= hi_pend_q;
			case (state_q)
				vram_pkg::FETCH_IDLE: begin
					if (fetch_start && !hi_pend_q) begin
						state_q <= vram_pkg::FETCH_MAP;
					end
				end
				vram_pkg::FETCH_MAP:  state_q <= vram_pkg::FETCH_LOW;
				vram_pkg::FETCH_LOW:  state_q <= vram_pkg::FETCH_HIGH;
				default:              state_q <= vram_pkg::FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_start && !fetch_busy) begin
			col_q      <= fetch_col;
			line_q     <= line_y;
			map_sel_q  <= lcdc_map_sel;
			tile_sel_q <= lcdc_tile_sel;
		end
		if (state_q == vram_pkg::FETCH_LOW) begin
			idx_q <= fetch_rdata;
		end
		if (state_q == vram_pkg::FETCH_HIGH) begin
			lo_q <= fetch_rdata;
		end
		if (hi_pend_q) begin
			tile_lo <= lo_q;
			tile_hi <= fetch_rdata; // High plane lands here.
		end
	end

endmodule

// ==== source/oam_dma.sv ====
`timescale 1ns/1ps

module oam_dma (
	input  logic                 clk,
	input  logic                 arst_n,
	input  vram_pkg::cpu_addr_t  cpu_addr,
	input  vram_pkg::byte_t      cpu_wdata,
	input  logic                 cpu_wr,
	output logic                 dma_req,
	output vram_pkg::vram_addr_t dma_addr,
	input  logic                 dma_gnt,
	input  vram_pkg::byte_t      dma_rdata,
	output logic                 dma_busy,
	output logic                 oam_we,
	output vram_pkg::oam_addr_t  oam_addr,
	output vram_pkg::byte_t      oam_wdata
);

	vram_pkg::dma_state_t state_q;
	vram_pkg::oam_addr_t  rd_cnt_q;
	vram_pkg::oam_addr_t  wr_cnt_q;
	logic                 wr_vld_q;
	vram_pkg::vram_addr_t src_base_q;
	logic                 start;

	// Only pages inside the VRAM window are accepted.
	assign start = cpu_wr && (cpu_addr == vram_pkg::DMA_REG_ADDR) &&
		(cpu_wdata >= vram_pkg::DMA_PAGE_FIRST) &&
		(cpu_wdata <= vram_pkg::DMA_PAGE_LAST) &&
		(state_q == vram_pkg::DMA_IDLE);

	assign dma_busy = (state_q == vram_pkg::DMA_RUN);
	assign dma_req  = dma_busy && (rd_cnt_q != vram_pkg::DMA_BYTES);
	assign dma_addr = src_base_q + vram_pkg::vram_addr_t'(rd_cnt_q);

	assign oam_we    = wr_vld_q;
	assign oam_addr  = wr_cnt_q;
	assign oam_wdata = dma_rdata;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q  <= vram_pkg::DMA_IDLE;
			rd_cnt_q <= '0;
			wr_cnt_q <= '0;
			wr_vld_q <= 1'b0;
		end else begin
			wr_vld_q <= dma_gnt;
			wr_cnt_q <= rd_cnt_q; // Write stage trails the read.
			if (start) begin
				state_q  <= vram_pkg::DMA_RUN;
				rd_cnt_q <= '0;
			end else if (dma_gnt) begin
				rd_cnt_q <= rd_cnt_q + 8'd1;
			end
			if (wr_vld_q && (wr_cnt_q == vram_pkg::DMA_BYTES - 8'd1)) begin
				state_q <= vram_pkg::DMA_IDLE; // Last byte written.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			src_base_q <= vram_pkg::vram_addr_t'({cpu_wdata, 8'h00} - vram_pkg::VRAM_WIN_BASE);
		end
	end

endmodule

// ==== source/vram_interface.sv ====
`timescale 1ns/1ps

module vram_interface (
	input  logic                 clk,
	input  logic                 arst_n,

	input  vram_pkg::cpu_addr_t  cpu_addr,
	input  vram_pkg::byte_t      cpu_wdata,
	input  logic                 cpu_rd,
	input  logic                 cpu_wr,

	input  logic                 ppu_mode3,
	input  logic                 dma_busy,

	input  logic                 fetch_req,
	input  vram_pkg::vram_addr_t fetch_addr,
	input  logic                 dma_req,
	input  vram_pkg::vram_addr_t dma_addr,
	output logic                 dma_gnt,

	output vram_pkg::byte_t      fetch_rdata,
	output vram_pkg::byte_t      dma_rdata,
	output vram_pkg::byte_t      cpu_rdata,
	output logic                 cpu_rvalid,

	output logic                 mem_cs,
	output logic                 mem_oe,
	output logic                 mem_we,
	output vram_pkg::vram_addr_t mem_addr,
	output vram_pkg::byte_t      mem_wdata,
	input  vram_pkg::byte_t      mem_rdata
);

	logic                 in_win;
	logic                 lockout;
	logic                 cpu_rd_go;
	logic                 cpu_wr_go;
	vram_pkg::vram_addr_t cpu_vaddr;

	logic own_fetch_q;
	logic own_dma_q;
	logic own_cpu_q;

	////////////////////////////////////////////////////////////
	// CPU window and lockout
	////////////////////////////////////////////////////////////

	assign in_win = (cpu_addr >= vram_pkg::VRAM_WIN_BASE) &&
		(cpu_addr <= vram_pkg::VRAM_WIN_LAST);
	assign cpu_vaddr = vram_pkg::vram_addr_t'(cpu_addr - vram_pkg::VRAM_WIN_BASE);

	// A collision with another client counts as a lockout.
	assign lockout = ppu_mode3 || dma_busy || fetch_req || dma_req;

	assign cpu_rd_go = cpu_rd && in_win && !lockout;
	assign cpu_wr_go = cpu_wr && in_win && !lockout;

	////////////////////////////////////////////////////////////
	// Arbitration and strobes
	////////////////////////////////////////////////////////////

	assign dma_gnt = dma_req && !fetch_req; // Fetcher always wins.

	assign mem_cs    = fetch_req || dma_gnt || cpu_rd_go || cpu_wr_go;
	assign mem_oe    = fetch_req || dma_gnt || cpu_rd_go;
	assign mem_we    = cpu_wr_go;
	assign mem_wdata = cpu_wdata;

	always_comb begin
		if (fetch_req) begin
			mem_addr = fetch_addr;
		end else if (dma_gnt) begin
			mem_addr = dma_addr;
		end else begin
			mem_addr = cpu_vaddr;
		end
	end

	////////////////////////////////////////////////////////////
	// Read-data steering
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			own_fetch_q <= 1'b0;
			own_dma_q   <= 1'b0;
			own_cpu_q   <= 1'b0;
			cpu_rvalid  <= 1'b0;
		end else begin
			own_fetch_q <= fetch_req;
			own_dma_q   <= dma_gnt;
			own_cpu_q   <= cpu_rd_go;
			cpu_rvalid  <= cpu_rd && in_win; // Blocked reads still answer.
		end
	end

	assign fetch_rdata = own_fetch_q ? mem_rdata : '0;
	assign dma_rdata   = own_dma_q ? mem_rdata : '0;
	assign cpu_rdata   = own_cpu_q ? mem_rdata : vram_pkg::BLOCKED_DATA;

endmodule

// ==== source/vram_pkg.sv ====
package vram_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	localparam int DATA_W      = 8;
	localparam int VRAM_ADDR_W = 13;
	localparam int CPU_ADDR_W  = 16;
	localparam int VRAM_DEPTH  = 1 << VRAM_ADDR_W;

	typedef logic [DATA_W-1:0]      byte_t;
	typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;
	typedef logic [CPU_ADDR_W-1:0]  cpu_addr_t;
	typedef logic [7:0]             oam_addr_t;
	typedef logic [4:0]             tile_col_t;
	typedef logic [7:0]             line_t;

	////////////////////////////////////////////////////////////
	// Address map
	////////////////////////////////////////////////////////////

	localparam cpu_addr_t VRAM_WIN_BASE = 16'h8000;
	localparam cpu_addr_t VRAM_WIN_LAST = VRAM_WIN_BASE + cpu_addr_t'(VRAM_DEPTH - 1);
	localparam cpu_addr_t DMA_REG_ADDR  = 16'hFF46;

	localparam byte_t DMA_PAGE_FIRST = VRAM_WIN_BASE[15:8];
	localparam byte_t DMA_PAGE_LAST  = VRAM_WIN_LAST[15:8];
	localparam oam_addr_t DMA_BYTES  = 8'd160;

	localparam vram_addr_t BG_MAP0_BASE     = 13'h1800;
	localparam vram_addr_t BG_MAP1_BASE     = 13'h1C00;
	localparam vram_addr_t TILE_SIGNED_BASE = 13'h1000;

	localparam byte_t BLOCKED_DATA = 8'hFF; // Seen by a locked-out CPU read.

	typedef enum logic [1:0] {FETCH_IDLE, FETCH_MAP, FETCH_LOW, FETCH_HIGH} fetch_state_t;
	typedef enum logic {DMA_IDLE, DMA_RUN} dma_state_t;

endpackage

// ==== source/vram_sram.sv ====
`timescale 1ns/1ps

module vram_sram (
	input  logic               clk,
	input  logic               cs,
	input  logic               oe,
	input  logic               we,
	input  vram_pkg::vram_addr_t addr,
	input  vram_pkg::byte_t      wdata,
	output vram_pkg::byte_t      rdata
);

	vram_pkg::byte_t mem [vram_pkg::VRAM_DEPTH];

	always_ff @(posedge clk) begin
		if (cs && we) begin
			mem[addr] <= wdata;
		end
	end

	// Read port holds its output between reads.
	always_ff @(posedge clk) begin
		if (cs && oe) begin
			rdata <= mem[addr];
		end
	end

endmodule

// ==== source/vram_subsystem.sv ====
`timescale 1ns/1ps

module vram_subsystem (
	input  logic                clk,
	input  logic                arst_n,

	input  vram_pkg::cpu_addr_t cpu_addr,
	input  vram_pkg::byte_t     cpu_wdata,
	input  logic                cpu_rd,
	input  logic                cpu_wr,
	output vram_pkg::byte_t     cpu_rdata,
	output logic                cpu_rvalid,

	input  logic                ppu_mode3,
	input  logic                fetch_start,
	input  vram_pkg::tile_col_t fetch_col,
	input  vram_pkg::line_t     line_y,
	input  logic                lcdc_map_sel,
	input  logic                lcdc_tile_sel,
	output vram_pkg::byte_t     tile_lo,
	output vram_pkg::byte_t     tile_hi,
	output logic                tile_valid,
	output logic                fetch_busy,

	output logic                dma_busy,
	output logic                oam_we,
	output vram_pkg::oam_addr_t oam_addr,
	output vram_pkg::byte_t     oam_wdata
);

	logic                 fetch_req;
	vram_pkg::vram_addr_t fetch_addr;
	vram_pkg::byte_t      fetch_rdata;

	logic                 dma_req;
	logic                 dma_gnt;
	vram_pkg::vram_addr_t dma_addr;
	vram_pkg::byte_t      dma_rdata;

	logic                 mem_cs;
	logic                 mem_oe;
	logic                 mem_we;
	vram_pkg::vram_addr_t mem_addr;
	vram_pkg::byte_t      mem_wdata;
	vram_pkg::byte_t      mem_rdata;

	////////////////////////////////////////////////////////////
	// Bus arbiter
	////////////////////////////////////////////////////////////

	vram_interface vram_interface_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.cpu_addr    (cpu_addr),
		.cpu_wdata   (cpu_wdata),
		.cpu_rd      (cpu_rd),
		.cpu_wr      (cpu_wr),
		.ppu_mode3   (ppu_mode3),
		.dma_busy    (dma_busy),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.dma_req     (dma_req),
		.dma_addr    (dma_addr),
		.dma_gnt     (dma_gnt),
		.fetch_rdata (fetch_rdata),
		.dma_rdata   (dma_rdata),
		.cpu_rdata   (cpu_rdata),
		.cpu_rvalid  (cpu_rvalid),
		.mem_cs      (mem_cs),
		.mem_oe      (mem_oe),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_rdata   (mem_rdata)
	);

	////////////////////////////////////////////////////////////
	// Clients and memory
	////////////////////////////////////////////////////////////

	bg_tile_fetcher bg_tile_fetcher_inst (
		.clk           (clk),
		.arst_n        (arst_n),
		.fetch_start   (fetch_start),
		.fetch_col     (fetch_col),
		.line_y        (line_y),
		.lcdc_map_sel  (lcdc_map_sel),
		.lcdc_tile_sel (lcdc_tile_sel),
		.fetch_req     (fetch_req),
		.fetch_addr    (fetch_addr),
		.fetch_rdata   (fetch_rdata),
		.tile_lo       (tile_lo),
		.tile_hi       (tile_hi),
		.tile_valid    (tile_valid),
		.fetch_busy    (fetch_busy)
	);

	oam_dma oam_dma_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_wr    (cpu_wr),
		.dma_req   (dma_req),
		.dma_addr  (dma_addr),
		.dma_gnt   (dma_gnt),
		.dma_rdata (dma_rdata),
		.dma_busy  (dma_busy),
		.oam_we    (oam_we),
		.oam_addr  (oam_addr),
		.oam_wdata (oam_wdata)
	);

	vram_sram vram_sram_inst (
		.clk   (clk),
		.cs    (mem_cs),
		.oe    (mem_oe),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

endmodule

// ==== vram_subsystem.f ====
source/vram_pkg.sv
source/vram_sram.sv
source/vram_interface.sv
source/bg_tile_fetcher.sv
source/oam_dma.sv
source/vram_subsystem.sv
dv/vram_subsystem_tb.sv
